/* Bender.yml */
package:
  name: prom_loader

sources:
  # RTL in compile order
  - files:
      - verilog/prom_loader_pkg.sv
      - verilog/cclk_generator.sv
      - verilog/prom_deserializer.sv
      - verilog/byte_buffer.sv
      - verilog/sync_detector.sv
      - verilog/prom_loader_top.sv

  # testbench
  - target: simulation
    files:
      - tb/serial_prom_model.sv
      - tb/tb_prom_loader.sv

/* list.f */
verilog/prom_loader_pkg.sv
verilog/cclk_generator.sv
verilog/prom_deserializer.sv
verilog/byte_buffer.sv
verilog/sync_detector.sv
verilog/prom_loader_top.sv
tb/serial_prom_model.sv
tb/tb_prom_loader.sv

/* tb/serial_prom_model.sv */
// serial configuration PROM model

`timescale 1ns/100ps

module serial_prom_model #(
	parameter int IMG_BYTES = 64
) (
	input  logic                   arst_n,
	input  logic                   cclk,
	input  logic [IMG_BYTES*8-1:0] image,
	output logic                   prom_data
);

	localparam int IMG_BITS = IMG_BYTES * 8;

	// **********************************************************************
	// internal address counter
	// **********************************************************************

	// index of the bit now on the data line
	int bit_idx;

	// address steps once per rising cclk, so the data changes right after it
	// and is stable again well before the next falling edge
	always @(posedge cclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_idx <= 0;
		end
		else
		begin
			bit_idx <= bit_idx + 1;
		end
	end

	// **********************************************************************
	// data line
	// **********************************************************************

	// msb of byte 0 sits at the top of the image vector
	// past the end of the image the line reads low
	assign prom_data = (bit_idx < IMG_BITS) ? image[IMG_BITS - 1 - bit_idx] : 1'b0;

endmodule

/* tb/tb_prom_loader.sv */
// PROM loader testbench

`timescale 1ns/100ps

module tb_prom_loader;

	import prom_loader_pkg::*;

	localparam int IMG_BYTES = 64;
	localparam int FRAME1_LEN = 12;
	localparam int FRAME2_LEN = 5;
	// eight cclk bits of eight system cycles per byte and twice that for stalls
	localparam int TIMEOUT_CYCLES = IMG_BYTES * 8 * 8 * 2 + 500;

	logic                   clock;
	logic                   arst_n;
	logic                   run;
	logic                   prom_data;
	logic                   cclk;
	logic                   out_valid;
	logic [BYTE_W-1:0]      out_data;
	logic                   out_last;
	logic                   out_ready;
	logic                   synced;
	logic [IMG_BYTES*8-1:0] image_bits;

	logic [7:0] image_bytes [IMG_BYTES];
	int         img_pos;
	integer     seed = 95344;
	// expected payload bytes and their last flags
	logic [7:0] exp_data [$];
	bit         exp_last [$];
	int         accepted_cnt = 0;
	int         compare_errs = 0;
	int         level_errs = 0;
	int         tests_passed = 0;
	int         tests_failed = 0;
	int         cycle_cnt = 0;

	prom_loader_top prom_loader_top_i (
		.clock     (clock),
		.arst_n    (arst_n),
		.run       (run),
		.prom_data (prom_data),
		.cclk      (cclk),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_last  (out_last),
		.out_ready (out_ready),
		.synced    (synced)
	);

	serial_prom_model #(
		.IMG_BYTES (IMG_BYTES)
	) serial_prom_model_i (
		.arst_n    (arst_n),
		.cclk      (cclk),
		.image     (image_bits),
		.prom_data (prom_data)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// **********************************************************************
	// image and reference stream
	// **********************************************************************

	task automatic put_byte(input logic [7:0] value);
		image_bytes[img_pos] = value;
		img_pos++;
	endtask

	// random bytes where filler never holds the first sync byte
	task automatic put_random(input int count, input bit filler);
		logic [31:0] rnd;
		int          k;
		for (k = 0; k < count; k++)
		begin
			rnd = $random(seed);
			if (filler && rnd[7:0] == 8'hAA)
			begin
				rnd[7:0] = 8'h5A;
			end
			put_byte(rnd[7:0]);
		end
	endtask

	task automatic put_header(input logic [15:0] length);
		put_byte(SYNC_WORD[31:24]);
		put_byte(SYNC_WORD[23:16]);
		put_byte(SYNC_WORD[15:8]);
		put_byte(SYNC_WORD[7:0]);
		put_byte(length[15:8]);
		put_byte(length[7:0]);
	endtask

	task automatic build_image();
		int k;
		img_pos = 0;
		put_random(10, 1'b1);
		put_header(16'(FRAME1_LEN));
		put_random(FRAME1_LEN, 1'b0);
		put_random(22, 1'b1);
		put_header(16'(FRAME2_LEN));
		put_random(FRAME2_LEN, 1'b0);
		put_random(IMG_BYTES - img_pos, 1'b1);
		// byte 0 goes out first and sits at the top
		for (k = 0; k < IMG_BYTES; k++)
		begin
			image_bits[(IMG_BYTES - 1 - k) * 8 +: 8] = image_bytes[k];
		end
	endtask

	// walk the image byte by byte and hunt the sync word in a 32-bit window
	// then take a big-endian length and that many payload bytes
	function automatic void expected_stream();
		detect_state_t phase;
		logic [31:0]   win;
		logic [15:0]   remaining;
		logic [7:0]    b;
		int            k;
		phase = HUNT;
		win = '0;
		remaining = '0;
		exp_data.delete();
		exp_last.delete();
		for (k = 0; k < IMG_BYTES; k++)
		begin
			b = image_bytes[k];
			case (phase)
				HUNT:
				begin
					win = {win[23:0], b};
					if (win == SYNC_WORD)
					begin
						win = '0;
						phase = LEN_HI;
					end
				end
				LEN_HI:
				begin
					remaining[15:8] = b;
					phase = LEN_LO;
				end
				LEN_LO:
				begin
					remaining[7:0] = b;
					if (remaining == 16'd0)
						phase = HUNT;
					else
						phase = DATA;
				end
				default:
				begin
					remaining = remaining - 16'd1;
					exp_data.push_back(b);
					exp_last.push_back(remaining == 16'd0);
					if (remaining == 16'd0)
						phase = HUNT;
				end
			endcase
		end
	endfunction

	// **********************************************************************
	// helpers
	// **********************************************************************

	task automatic drive_run(input logic value);
		@(posedge clock);
		#2;
		run = value;
	endtask

	task automatic drive_ready(input logic value);
		@(posedge clock);
		#2;
		out_ready = value;
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		assert (got === want)
		else
		begin
			$display("mismatch %s: expected 0x%h, got 0x%h", name, want, got);
			level_errs++;
		end
	endtask

	task automatic wait_accepted(input int count);
		while (accepted_cnt < count)
			@(posedge clock);
	endtask

	task automatic wait_cclk_falls(input int falls);
		int   seen;
		logic prev;
		seen = 0;
		prev = cclk;
		while (seen < falls)
		begin
			@(negedge clock);
			if (prev === 1'b1 && cclk === 1'b0)
				seen++;
			prev = cclk;
		end
	endtask

	// length of each cclk phase in system cycles starting at a falling edge
	task automatic measure_cclk(input int periods);
		int len;
		int p;
		@(negedge clock);
		while (cclk !== 1'b1)
			@(negedge clock);
		while (cclk !== 1'b0)
			@(negedge clock);
		for (p = 0; p < periods; p++)
		begin
			len = 0;
			while (cclk === 1'b0)
			begin
				len++;
				@(negedge clock);
			end
			assert (len == CCLK_HALF)
			else
			begin
				$display("mismatch cclk low cycles: expected 0x%h, got 0x%h", CCLK_HALF, len);
				level_errs++;
			end
			len = 0;
			while (cclk === 1'b1)
			begin
				len++;
				@(negedge clock);
			end
			assert (len == CCLK_HALF)
			else
			begin
				$display("mismatch cclk high cycles: expected 0x%h, got 0x%h", CCLK_HALF, len);
				level_errs++;
			end
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		if (errs == 0)
		begin
			tests_passed++;
			$display("test %0d %s: pass", num, name);
		end
		else
		begin
			tests_failed++;
			$display("test %0d %s: FAIL with %0d errors", num, name, errs);
		end
	endtask

	// **********************************************************************
	// output compare where the handshake completes on the next rising edge
	// **********************************************************************
	always @(negedge clock)
	begin
		if (arst_n === 1'b1 && out_valid === 1'b1 && out_ready === 1'b1)
		begin
			assert (accepted_cnt < exp_data.size())
			else
			begin
				$display("byte 0x%h arrived after the expected stream ended", out_data);
				compare_errs++;
			end
			if (accepted_cnt < exp_data.size())
			begin
				assert (out_data === exp_data[accepted_cnt])
				else
				begin
					$display("mismatch out_data: expected 0x%h, got 0x%h",
						exp_data[accepted_cnt], out_data);
					compare_errs++;
				end
				assert (out_last === exp_last[accepted_cnt])
				else
				begin
					$display("mismatch out_last: expected 0x%h, got 0x%h",
						exp_last[accepted_cnt], out_last);
					compare_errs++;
				end
			end
			assert (synced === 1'b1)
			else
			begin
				$display("mismatch synced: expected 0x1, got 0x%h", synced);
				compare_errs++;
			end
			accepted_cnt++;
		end
	end

	// run limit
	initial
	begin
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles with %0d bytes accepted", cycle_cnt, accepted_cnt);
		$display("Simulation failed");
		$finish;
	end

	// **********************************************************************
	// test sequence
	// **********************************************************************
	initial
	begin : main_flow
		int lvl_start;
		int bp_errs;
		int pause_errs;
		int cmp_start;
		int cmp_release;
		int cmp_pause;
		int cmp_frame1;
		int i;
		arst_n = 1'b0;
		run = 1'b0;
		out_ready = 1'b0;
		image_bits = '0;
		build_image();
		expected_stream();
		assert (exp_data.size() == FRAME1_LEN + FRAME2_LEN)
		else
		begin
			$display("reference holds %0d payload bytes instead of %0d",
				exp_data.size(), FRAME1_LEN + FRAME2_LEN);
			level_errs++;
		end
		repeat (3) @(posedge clock);
		#2;
		arst_n = 1'b1;

		// idle with run low
		lvl_start = level_errs;
		repeat (50)
		begin
			@(negedge clock);
			check_bit("cclk", cclk, 1'b1);
			check_bit("out_valid", out_valid, 1'b0);
			check_bit("out_last", out_last, 1'b0);
			check_bit("synced", synced, 1'b0);
		end
		report_test(1, "reset and idle", level_errs - lvl_start);

		// cclk phases while the buffer still has room
		lvl_start = level_errs;
		cmp_start = compare_errs;
		drive_ready(1'b1);
		drive_run(1'b1);
		measure_cclk(3);
		report_test(2, "clock timing", level_errs - lvl_start);

		// stall the output a few bytes into the first frame
		wait_accepted(4);
		lvl_start = level_errs;
		drive_ready(1'b0);
		for (i = 0; i < 2000; i++)
		begin
			@(negedge clock);
			// by now the producer has run out of credits
			if (i >= 1900)
				check_bit("cclk", cclk, 1'b1);
		end
		bp_errs = level_errs - lvl_start;
		drive_ready(1'b1);
		cmp_release = compare_errs;

		// stop the load three bits into a byte
		wait_cclk_falls(3);
		lvl_start = level_errs;
		drive_run(1'b0);
		cmp_pause = compare_errs;
		for (i = 0; i < 300; i++)
		begin
			@(negedge clock);
			// cclk parks high one cycle after run drops
			if (i >= 1)
				check_bit("cclk", cclk, 1'b1);
		end
		pause_errs = level_errs - lvl_start;
		drive_run(1'b1);

		wait_accepted(FRAME1_LEN);
		cmp_frame1 = compare_errs;
		report_test(3, "first frame", cmp_frame1 - cmp_start);
		report_test(4, "back-pressure", bp_errs + cmp_frame1 - cmp_release);

		// synced drops on the edge that takes the last payload byte
		wait_accepted(FRAME1_LEN + FRAME2_LEN);
		@(negedge clock);
		lvl_start = level_errs;
		check_bit("synced", synced, 1'b0);
		report_test(5, "pausing the load", pause_errs + compare_errs - cmp_pause);
		report_test(6, "second frame", level_errs - lvl_start + compare_errs - cmp_frame1);

		$display("tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, level_errs + compare_errs);
		if (tests_failed == 0 && level_errs + compare_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* verilog/byte_buffer.sv */
// credit controlled byte FIFO

`timescale 1ns/100ps

module byte_buffer (
	input  logic                               clock,
	input  logic                               arst_n,
	input  logic                               prod_valid,
	input  logic [prom_loader_pkg::BYTE_W-1:0] prod_data,
	output logic                               prod_credit,
	output logic                               cons_valid,
	output logic [prom_loader_pkg::BYTE_W-1:0] cons_data,
	input  logic                               cons_credit
);

	import prom_loader_pkg::*;

	logic [BYTE_W-1:0]      mem [BUF_DEPTH];
	logic [BUF_AW-1:0]      wr_ptr;
	logic [BUF_AW-1:0]      rd_ptr;
	logic [BUF_CNT_W-1:0]   count;
	// free slots in the consumer
	logic [CONS_CRED_W-1:0] dn_credits;
	logic                   pop;

	// an incoming byte may pass straight through an empty buffer
	assign pop = ((count != '0) | prod_valid) & (dn_credits != '0);

	// **********************************************************************
	// pointers, fill level and downstream credits
	// **********************************************************************
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			dn_credits <= CONS_CRED_W'(CONS_CREDITS);
			cons_valid <= 1'b0;
			prod_credit <= 1'b0;
		end
		else
		begin
			if (prod_valid)
			begin
				wr_ptr <= wr_ptr + BUF_AW'(1);
			end
			if (pop)
			begin
				rd_ptr <= rd_ptr + BUF_AW'(1);
			end
			if (prod_valid && !pop)
			begin
				count <= count + BUF_CNT_W'(1);
			end
			else if (!prod_valid && pop)
			begin
				count <= count - BUF_CNT_W'(1);
			end
			if (pop && !cons_credit)
			begin
				dn_credits <= dn_credits - CONS_CRED_W'(1);
			end
			else if (!pop && cons_credit)
			begin
				dn_credits <= dn_credits + CONS_CRED_W'(1);
			end
			cons_valid <= pop;
			// freed entry goes back to the producer one cycle after the pop
			prod_credit <= pop;
		end
	end

	// storage and output byte
	always_ff @(posedge clock)
	begin
		if (prod_valid)
		begin
			mem[wr_ptr] <= prod_data;
		end
		if (pop)
		begin
			cons_data <= (count == '0) ? prod_data : mem[rd_ptr];
		end
	end

	// producer credits must keep pushes off a full buffer
	assert property (@(posedge clock) disable iff (!arst_n)
		prod_valid |-> count != BUF_CNT_W'(BUF_DEPTH));

	// an empty buffer keeps its read pointer on the next write slot
	// and holds nothing stale to pop
	assert property (@(posedge clock) disable iff (!arst_n)
		count == '0 |-> rd_ptr == wr_ptr);

endmodule

/* verilog/cclk_generator.sv */
// PROM clock divider

`timescale 1ns/100ps

module cclk_generator (
	input  logic clock,
	input  logic arst_n,
	input  logic enable,
	output logic cclk,
	output logic sample
);

	import prom_loader_pkg::*;

	// half period counter
	logic [CCLK_CNT_W-1:0] half_cnt;
	logic                  terminal;

	// last system cycle of the current cclk half period
	assign terminal = (half_cnt == CCLK_CNT_W'(CCLK_HALF - 1));

	// **********************************************************************
	// divider, cclk parks high and the count restarts while disabled
	// **********************************************************************
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			half_cnt <= '0;
			cclk <= 1'b1;
			sample <= 1'b0;
		end
		else if (!enable)
		begin
			half_cnt <= '0;
			cclk <= 1'b1;
			sample <= 1'b0;
		end
		else
		begin
			if (terminal)
			begin
				half_cnt <= '0;
				cclk <= ~cclk;
			end
			else
			begin
				half_cnt <= half_cnt + CCLK_CNT_W'(1);
			end
			// sample lands in the same cycle as the falling cclk edge
			sample <= terminal & cclk;
		end
	end

	// a disabled divider must not produce a sample on the next cycle
	assert property (@(posedge clock) disable iff (!arst_n)
		!enable |=> !sample);

	// cclk returns high within one cycle of the enable dropping
	assert property (@(posedge clock) disable iff (!arst_n)
		!enable |=> cclk);

endmodule

/* verilog/prom_deserializer.sv */
// PROM bit deserializer

`timescale 1ns/100ps

module prom_deserializer (
	input  logic                               clock,
	input  logic                               arst_n,
	input  logic                               run,
	input  logic                               prom_data,
	output logic                               cclk,
	output logic                               prod_valid,
	output logic [prom_loader_pkg::BYTE_W-1:0] prod_data,
	input  logic                               prod_credit
);

	import prom_loader_pkg::*;

	logic                 sample;
	logic                 cclk_en;
	// bits already taken into the current byte
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [BYTE_W-1:0]    shift_reg;
	// free buffer entries as seen from here
	logic [PCRED_W-1:0]   credits;
	logic                 last_bit;
	logic                 spend;

	assign last_bit = (bit_cnt == BIT_CNT_W'(BYTE_W - 1));
	// eighth sample completes a byte and uses up one credit
	assign spend = sample & last_bit;

	// a new byte only starts with a credit in hand
	// a partly shifted byte is always finished
	assign cclk_en = run & ((credits != '0) | (bit_cnt != '0));

	cclk_generator cclk_generator_i (
		.clock  (clock),
		.arst_n (arst_n),
		.enable (cclk_en),
		.cclk   (cclk),
		.sample (sample)
	);

	// **********************************************************************
	// bit counter, byte strobe and credits
	// **********************************************************************
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_cnt <= '0;
			prod_valid <= 1'b0;
			credits <= PCRED_W'(BUF_DEPTH);
		end
		else
		begin
			if (sample)
			begin
				bit_cnt <= bit_cnt + BIT_CNT_W'(1);
			end
			prod_valid <= spend;
			// spend and return in one cycle cancel out
			if (spend && !prod_credit)
			begin
				credits <= credits - PCRED_W'(1);
			end
			else if (!spend && prod_credit)
			begin
				credits <= credits + PCRED_W'(1);
			end
		end
	end

	// **********************************************************************
	// shift path, msb arrives first
	// **********************************************************************
	always_ff @(posedge clock)
	begin
		if (sample)
		begin
			shift_reg <= {shift_reg[BYTE_W-2:0], prom_data};
		end
		if (spend)
		begin
			prod_data <= {shift_reg[BYTE_W-2:0], prom_data};
		end
	end

	// a byte is only issued against a credit held when it completed
	assert property (@(posedge clock) disable iff (!arst_n)
		prod_valid |-> $past(credits) != '0);

	// returns can never exceed what the buffer holds
	assert property (@(posedge clock) disable iff (!arst_n)
		credits <= PCRED_W'(BUF_DEPTH));

endmodule

/* verilog/prom_loader_pkg.sv */
// PROM loader shared definitions

package prom_loader_pkg;

	// **********************************************************************
	// cclk divider
	// **********************************************************************

	// system clock cycles per cclk half period
	localparam int CCLK_HALF = 4;
	localparam int CCLK_CNT_W = $clog2(CCLK_HALF);

	// **********************************************************************
	// byte path and buffering
	// **********************************************************************

	localparam int BYTE_W = 8;
	// bit position counter inside one byte
	localparam int BIT_CNT_W = $clog2(BYTE_W);

	// buffer entries, also the producer's starting credit count
	localparam int BUF_DEPTH = 8;
	localparam int BUF_AW = 3;
	// fill count needs one more bit than the pointers
	localparam int BUF_CNT_W = BUF_AW + 1;
	// producer credit counter holds 0 .. BUF_DEPTH
	localparam int PCRED_W = $clog2(BUF_DEPTH + 1);

	// consumer input slots, also the buffer's starting downstream credits
	localparam int CONS_CREDITS = 1;
	localparam int CONS_CRED_W = $clog2(CONS_CREDITS + 1);

	// **********************************************************************
	// frame format
	// **********************************************************************

	localparam int SYNC_W = 32;
	localparam logic [SYNC_W-1:0] SYNC_WORD = 32'hAA995566;
	// big-endian payload length field
	localparam int LEN_W = 16;

	// detector states
	typedef enum logic [1:0] {
		HUNT,
		LEN_HI,
		LEN_LO,
		DATA
	} detect_state_t;

endpackage

/* verilog/prom_loader_top.sv */
// serial PROM loader top

`timescale 1ns/100ps

module prom_loader_top (
	input  logic                               clock,
	input  logic                               arst_n,
	input  logic                               run,
	input  logic                               prom_data,
	output logic                               cclk,
	output logic                               out_valid,
	output logic [prom_loader_pkg::BYTE_W-1:0] out_data,
	output logic                               out_last,
	input  logic                               out_ready,
	output logic                               synced
);

	import prom_loader_pkg::*;

	// producer to buffer
	logic              prod_valid;
	logic [BYTE_W-1:0] prod_data;
	logic              prod_credit;

	// buffer to consumer
	logic              cons_valid;
	logic [BYTE_W-1:0] cons_data;
	logic              cons_credit;

	prom_deserializer prom_deserializer_i (
		.clock       (clock),
		.arst_n      (arst_n),
		.run         (run),
		.prom_data   (prom_data),
		.cclk        (cclk),
		.prod_valid  (prod_valid),
		.prod_data   (prod_data),
		.prod_credit (prod_credit)
	);

	byte_buffer byte_buffer_i (
		.clock       (clock),
		.arst_n      (arst_n),
		.prod_valid  (prod_valid),
		.prod_data   (prod_data),
		.prod_credit (prod_credit),
		.cons_valid  (cons_valid),
		.cons_data   (cons_data),
		.cons_credit (cons_credit)
	);

	sync_detector sync_detector_i (
		.clock       (clock),
		.arst_n      (arst_n),
		.cons_valid  (cons_valid),
		.cons_data   (cons_data),
		.cons_credit (cons_credit),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_last    (out_last),
		.out_ready   (out_ready),
		.synced      (synced)
	);

endmodule

/* verilog/sync_detector.sv */
// sync word detector and payload forwarder

`timescale 1ns/100ps

module sync_detector (
	input  logic                               clock,
	input  logic                               arst_n,
	input  logic                               cons_valid,
	input  logic [prom_loader_pkg::BYTE_W-1:0] cons_data,
	output logic                               cons_credit,
	output logic                               out_valid,
	output logic [prom_loader_pkg::BYTE_W-1:0] out_data,
	output logic                               out_last,
	input  logic                               out_ready,
	output logic                               synced
);

	import prom_loader_pkg::*;

	detect_state_t     state;
	// single input slot
	logic              in_valid;
	logic [BYTE_W-1:0] in_data;
	logic [SYNC_W-1:0] window;
	logic [SYNC_W-1:0] next_window;
	// payload bytes still to forward
	logic [LEN_W-1:0]  len_cnt;
	logic [LEN_W-1:0]  len_full;
	logic              header_take;
	logic              handshake;

	assign next_window = {window[SYNC_W-BYTE_W-1:0], in_data};
	assign len_full = {len_cnt[LEN_W-1:BYTE_W], in_data};
	// header bytes are used up one cycle after they arrive
	assign header_take = in_valid & (state != DATA);

	// payload is shown straight from the input slot
	assign out_valid = in_valid & (state == DATA);
	assign out_data = in_data;
	assign out_last = out_valid & (len_cnt == LEN_W'(1));
	assign handshake = out_valid & out_ready;

	// **********************************************************************
	// input slot and credit return
	// **********************************************************************
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			in_valid <= 1'b0;
			cons_credit <= 1'b0;
		end
		else
		begin
			if (cons_valid)
			begin
				in_valid <= 1'b1;
			end
			else if (header_take || handshake)
			begin
				in_valid <= 1'b0;
			end
			// slot freed last cycle, hand the credit back
			cons_credit <= header_take | handshake;
		end
	end

	always_ff @(posedge clock)
	begin
		if (cons_valid)
		begin
			in_data <= cons_data;
		end
	end

	// **********************************************************************
	// frame FSM
	// **********************************************************************
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= HUNT;
			window <= '0;
			len_cnt <= '0;
			synced <= 1'b0;
		end
		else
		begin
			case (state)
				HUNT:
				begin
					if (in_valid)
					begin
						window <= next_window;
						if (next_window == SYNC_WORD)
						begin
							// flush so stale bytes cannot match again
							window <= '0;
							synced <= 1'b1;
							state <= LEN_HI;
						end
					end
				end
				LEN_HI:
				begin
					if (in_valid)
					begin
						len_cnt[LEN_W-1:BYTE_W] <= in_data;
						state <= LEN_LO;
					end
				end
				LEN_LO:
				begin
					if (in_valid)
					begin
						len_cnt <= len_full;
						if (len_full == '0)
						begin
							// empty frame, back to searching
							synced <= 1'b0;
							state <= HUNT;
						end
						else
						begin
							state <= DATA;
						end
					end
				end
				DATA:
				begin
					if (handshake)
					begin
						len_cnt <= len_cnt - LEN_W'(1);
						if (out_last)
						begin
							synced <= 1'b0;
							state <= HUNT;
						end
					end
				end
				default:
				begin
					state <= HUNT;
				end
			endcase
		end
	end

	// held output must not change until it is taken
	assert property (@(posedge clock) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

	// the buffer only sends against a returned credit
	assert property (@(posedge clock) disable iff (!arst_n)
		cons_valid |-> !in_valid);

endmodule
